// ==== Bender.yml ====
package:
  name: qpmm

sources:
  - hdl/qpmm_pkg.sv
  - hdl/qpmm_stage_if.sv
  - hdl/qpmm_pe.sv
  - hdl/qpmm_issue.sv
  - hdl/qpmm_row.sv
  - hdl/qpmm_final_add.sv
  - hdl/qpmm_mul.sv
  - target: simulation
    files:
      - bench/qpmm_tb.sv

// ==== bench/qpmm_tb.sv ====
`default_nettype none

module qpmm_tb;
    import qpmm_pkg::*;

    localparam int PE_LAT        = 1;
    localparam int LATENCY       = 3 + NUM_ROWS * PE_LAT;
    localparam int STREAM_LEN    = 200;
    localparam int SINGLE_COUNT  = 20;
    localparam int GAP_SLOTS     = 300;
    localparam int DRAIN_TIMEOUT = 100;

    // Row 0 starts from an empty sum, so only the rows below it divide by 2^16
    // and the product comes out scaled by 2^-64
    localparam int REDUCTIONS    = NUM_DIGITS;

    localparam logic [31:0] SEED = 32'h91cf_f92c;

    typedef logic [159:0] wide_t;

    typedef struct packed {
        operand_t    a;
        operand_t    b;
        result_t     expected;
        logic [31:0] cycle;
    } item_t;

    logic     clk = 1'b0;
    logic     reset;
    logic     in_valid;
    operand_t in_a;
    operand_t in_b;
    logic     out_valid;
    result_t  out_z;

    logic [31:0] lcg_state;
    logic [31:0] cycle_count;
    int          in_count;
    int          out_count;
    string       test_name;
    item_t       pending [$];
    operand_t    corner [6];

    qpmm_mul #(
        .PE_LAT (PE_LAT)
    ) i_qpmm_mul (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_a      (in_a),
        .in_b      (in_b),
        .out_valid (out_valid),
        .out_z     (out_z)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    //////////////////////////////////////////////////
    // Model and random source
    //////////////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic operand_t rand_operand();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return operand_t'({hi, lo} % MODULUS);
    endfunction

    // Montgomery reduction one digit at a time
    function automatic result_t mont_model(input operand_t a, input operand_t b);
        wide_t t;
        wide_t q;
        t = wide_t'(a) * wide_t'(b);
        for (int k = 0; k < REDUCTIONS; k++) begin
            // M is -1 mod 2^16, so q copies of M clear the low digit
            q = wide_t'(t[DIGIT_W-1:0]);
            t = (t + q * wide_t'(MODULUS)) >> DIGIT_W;
        end
        return result_t'(t % wide_t'(MODULUS));
    endfunction

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_result(input operand_t a, input operand_t b,
                                input result_t expected, input result_t actual);
        result_t residue;
        residue = actual % result_t'(MODULUS);
        if (residue !== expected) begin
            stop_with_failure($sformatf("ERR %s a=%h b=%h: expected %h, actual %h (z=%h)",
                test_name, a, b, expected, residue, actual));
        end
    endtask

    task automatic check_bound(input result_t actual);
        result_t limit;
        limit = result_t'(MODULUS) << 1;
        if (actual >= limit) begin
            stop_with_failure($sformatf("ERR %s bound: expected below %h, actual %h",
                test_name, limit, actual));
        end
    endtask

    task automatic check_count(input string what, input int expected, input int actual);
        if (actual != expected) begin
            stop_with_failure($sformatf("ERR %s %s: expected %0d, actual %0d",
                test_name, what, expected, actual));
        end
    endtask

    // Output side, sampled away from the rising edge
    always @(negedge clk) begin
        item_t item;
        if (out_valid !== 1'b0 && out_valid !== 1'b1) begin
            stop_with_failure("out_valid is unknown after the first clock edge");
        end else if (reset) begin
            if (out_valid) begin
                stop_with_failure("out_valid went high while reset was asserted");
            end
        end else if (out_valid) begin
            if (pending.size() == 0) begin
                stop_with_failure("out_valid went high with no operand pair in flight");
            end else begin
                item = pending.pop_front();
                check_result(item.a, item.b, item.expected, out_z);
                check_bound(out_z);
                check_count("latency", LATENCY, int'(cycle_count - item.cycle));
                out_count++;
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic drive_item(input operand_t a, input operand_t b);
        item_t item;
        @(negedge clk);
        in_valid = 1'b1;
        in_a = a;
        in_b = b;
        item.a = a;
        item.b = b;
        item.expected = mont_model(a, b);
        item.cycle = cycle_count;
        pending.push_back(item);
        in_count++;
    endtask

    task automatic drive_idle();
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (out_count != in_count) begin
            @(posedge clk);
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                stop_with_failure($sformatf(
                    "%s: out_valid never arrived for %0d pending operand pairs",
                    test_name, in_count - out_count));
            end
        end
    endtask

    initial begin
        reset = 1'b1;
        in_valid = 1'b0;
        in_a = '0;
        in_b = '0;
        cycle_count = '0;
        in_count = 0;
        out_count = 0;
        lcg_state = SEED;

        test_name = "reset";
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (10) drive_idle();

        // Isolated products
        test_name = "single";
        for (int n = 0; n < SINGLE_COUNT; n++) begin
            drive_item(rand_operand(), rand_operand());
            drive_idle();
            wait_drain();
            repeat (next_rand() % 4) drive_idle();
        end

        // Edge values, all below the modulus
        test_name = "corner";
        corner[0] = '0;
        corner[1] = 64'd1;
        corner[2] = MODULUS - 1;
        corner[3] = 64'h0000_FFFF_FFFF_FFFF;
        corner[4] = 64'h0000_FFFF_0000_FFFF;
        corner[5] = 64'hF3A9_0000_FFFF_FFFF;
        for (int i = 0; i < 6; i++) begin
            for (int j = 0; j < 6; j++) begin
                drive_item(corner[i], corner[j]);
            end
        end
        drive_idle();
        wait_drain();

        // Full rate, one pair per cycle
        test_name = "stream";
        out_count = 0;
        in_count = 0;
        for (int n = 0; n < STREAM_LEN; n++) begin
            drive_item(rand_operand(), rand_operand());
        end
        drive_idle();
        wait_drain();

        // Roughly three slots in four carry an item
        test_name = "gaps";
        out_count = 0;
        in_count = 0;
        for (int n = 0; n < GAP_SLOTS; n++) begin
            if (next_rand() % 4 != 0) begin
                drive_item(rand_operand(), rand_operand());
            end else begin
                drive_idle();
            end
        end
        drive_idle();
        wait_drain();

        // Any stray pulse in the idle tail has no pair left to match
        repeat (LATENCY + 2) drive_idle();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/qpmm_pkg.sv
hdl/qpmm_stage_if.sv
hdl/qpmm_pe.sv
hdl/qpmm_issue.sv
hdl/qpmm_row.sv
hdl/qpmm_final_add.sv
hdl/qpmm_mul.sv
bench/qpmm_tb.sv

// ==== hdl/qpmm_final_add.sv ====
`default_nettype none

module qpmm_final_add (
    input  logic              clk,
    input  logic              reset,
    qpmm_stage_if.dst         stage,
    output logic              out_valid,
    output qpmm_pkg::result_t out_z
);
    import qpmm_pkg::*;

    // Two sum digits at 16-bit spacing plus a small carry term
    localparam int HALF_W = ACC_W + DIGIT_W + 1;

    typedef logic [HALF_W-1:0] half_t;

    logic [1:0] valid_pipe;
    half_t      z_lo;
    half_t      z_hi;

    // Collapse two neighbouring sum digits into one integer
    function automatic half_t digits_to_int(input acc_t lo, input acc_t hi);
        return half_t'(lo) + (half_t'(hi) << DIGIT_W);
    endfunction

    //////////////////////////////////////////////////
    // Stage 1, resolve each half
    //////////////////////////////////////////////////

    // Digit j has weight 2^(16*(j-1)), digit 0 only adds its carry
    always_ff @(posedge clk) begin
        z_lo <= digits_to_int(stage.s[1], stage.s[2]) + half_t'(stage.s[0] >> DIGIT_W);
        z_hi <= digits_to_int(stage.s[3], stage.s[4]);
    end

    //////////////////////////////////////////////////
    // Stage 2, join the halves
    //////////////////////////////////////////////////

    // Sum stays below 2M, so truncation to the result width is exact
    always_ff @(posedge clk) begin
        out_z <= (result_t'(z_hi) << (2 * DIGIT_W)) + result_t'(z_lo);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[0], stage.valid};
        end
    end

    assign out_valid = valid_pipe[1];

endmodule

`default_nettype wire

// ==== hdl/qpmm_issue.sv ====
`default_nettype none

module qpmm_issue (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  qpmm_pkg::operand_t in_a,
    input  qpmm_pkg::operand_t in_b,
    qpmm_stage_if.src          stage
);
    import qpmm_pkg::*;

    logic       valid_q;
    digit_vec_t a_q;
    digit_vec_t b_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    // Operand registers, flat vector reinterpreted as digits
    always_ff @(posedge clk) begin
        a_q <= in_a;
        b_q <= in_b;
    end

    assign stage.valid = valid_q;
    assign stage.a     = a_q;
    assign stage.b     = b_q;

    // Row 0 starts from an empty sum, so its quotient is zero
    assign stage.s     = '0;

endmodule

`default_nettype wire

// ==== hdl/qpmm_mul.sv ====
`default_nettype none

module qpmm_mul #(
    parameter int PE_LAT = 1
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  qpmm_pkg::operand_t in_a,
    input  qpmm_pkg::operand_t in_b,
    output logic               out_valid,
    output qpmm_pkg::result_t  out_z
);
    import qpmm_pkg::*;

    // Link i feeds row i, the last one feeds the final adder
    qpmm_stage_if stage_bus [0:NUM_ROWS] ();

    //////////////////////////////////////////////////
    // Issue
    //////////////////////////////////////////////////

    qpmm_issue i_issue (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_a     (in_a),
        .in_b     (in_b),
        .stage    (stage_bus[0])
    );

    //////////////////////////////////////////////////
    // Reduction rows
    //////////////////////////////////////////////////

    for (genvar i = 0; i < NUM_ROWS; i++) begin : g_row
        qpmm_row #(
            .ROW    (i),
            .PE_LAT (PE_LAT)
        ) i_row (
            .clk   (clk),
            .reset (reset),
            .up    (stage_bus[i]),
            .down  (stage_bus[i+1])
        );
    end

    //////////////////////////////////////////////////
    // Carry resolution
    //////////////////////////////////////////////////

    qpmm_final_add i_final_add (
        .clk       (clk),
        .reset     (reset),
        .stage     (stage_bus[NUM_ROWS]),
        .out_valid (out_valid),
        .out_z     (out_z)
    );

endmodule

`default_nettype wire

// ==== hdl/qpmm_pe.sv ====
`default_nettype none

module qpmm_pe #(
    parameter int PE_LAT = 1
) (
    input  logic             clk,
    input  qpmm_pkg::digit_t a,
    input  qpmm_pkg::digit_t b,
    input  qpmm_pkg::digit_t m,
    input  qpmm_pkg::digit_t q,
    input  qpmm_pkg::acc_t   s,
    output qpmm_pkg::acc_t   sum
);
    import qpmm_pkg::*;

    acc_t mac;
    acc_t mac_pipe [PE_LAT];

    // a*b + m*q + s, one DSP multiply-accumulate
    // Both products are 32 bits at most
    assign mac = acc_t'(a) * acc_t'(b) + acc_t'(m) * acc_t'(q) + s;

    // Output registers, extra stages can be retimed into the DSP
    always_ff @(posedge clk) begin
        mac_pipe[0] <= mac;
        for (int k = 1; k < PE_LAT; k++) begin
            mac_pipe[k] <= mac_pipe[k-1];
        end
    end

    assign sum = mac_pipe[PE_LAT-1];

endmodule

`default_nettype wire

// ==== hdl/qpmm_pkg.sv ====
`default_nettype none

package qpmm_pkg;

    //////////////////////////////////////////////////
    // Digit geometry
    //////////////////////////////////////////////////

    localparam int DIGIT_W    = 16;
    localparam int NUM_DIGITS = 4;

    // One extra row after the last B digit to drain the quotient
    localparam int NUM_ROWS   = NUM_DIGITS + 1;

    // Two 32-bit products plus an incoming digit sum, with headroom
    localparam int ACC_W      = 40;

    localparam int OPERAND_W  = NUM_DIGITS * DIGIT_W;

    // Output is only reduced below 2M, so one bit above the operand
    localparam int RESULT_W   = OPERAND_W + 1;

    //////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////

    typedef logic [DIGIT_W-1:0]   digit_t;
    typedef logic [ACC_W-1:0]     acc_t;
    typedef logic [OPERAND_W-1:0] operand_t;
    typedef logic [RESULT_W-1:0]  result_t;

    // Operand split into digits, digit 0 is the least significant
    typedef logic [NUM_DIGITS-1:0][DIGIT_W-1:0] digit_vec_t;

    // Redundant partial sum
    // Index 0 keeps the quotient sum, its upper bits carry into the next row
    typedef logic [NUM_DIGITS:0][ACC_W-1:0] acc_vec_t;

    //////////////////////////////////////////////////
    // Modulus
    //////////////////////////////////////////////////

    // Low digit all ones, so M' = -M^-1 mod 2^16 is 1
    // and the quotient digit is just the low digit of the running sum
    localparam operand_t MODULUS = 64'hF3A9_5C27_1D0B_FFFF;

    // (M + 1) / 2^16, exact because M + 1 has a zero low digit
    // Top digit comes out zero
    localparam digit_vec_t MPP =
        digit_vec_t'((result_t'(MODULUS) + 1'b1) >> DIGIT_W);

endpackage

`default_nettype wire

// ==== hdl/qpmm_row.sv ====
`default_nettype none

module qpmm_row #(
    parameter int ROW    = 0,
    parameter int PE_LAT = 1
) (
    input  logic      clk,
    input  logic      reset,
    qpmm_stage_if.dst up,
    qpmm_stage_if.src down
);
    import qpmm_pkg::*;

    acc_t              q_sum;
    digit_t            q;
    digit_t            b_sel;
    acc_t              pe_sum [NUM_DIGITS];

    logic [PE_LAT-1:0] valid_pipe;
    digit_vec_t        a_pipe [PE_LAT];
    digit_vec_t        b_pipe [PE_LAT];
    acc_t              q_pipe [PE_LAT];

    //////////////////////////////////////////////////
    // Quotient digit
    //////////////////////////////////////////////////

    // Carry out of the previous quotient sum plus the lowest sum digit
    assign q_sum = (up.s[0] >> DIGIT_W) + up.s[1];

    // M' is 1, no multiply needed here
    assign q = q_sum[DIGIT_W-1:0];

    // B digit for this row, the drain row only reduces
    if (ROW < NUM_DIGITS) begin : g_mul_row
        assign b_sel = up.b[ROW];
    end else begin : g_red_row
        assign b_sel = '0;
    end

    //////////////////////////////////////////////////
    // Digit cells
    //////////////////////////////////////////////////

    // Cell j produces sum digit j+1 from digit j+2 of the row above,
    // which divides the whole sum by 2^16
    for (genvar j = 0; j < NUM_DIGITS; j++) begin : g_cell
        acc_t s_in;

        if (j + 2 <= NUM_DIGITS) begin : g_sum
            assign s_in = up.s[j+2];
        end else begin : g_top
            // Nothing above the top digit
            assign s_in = '0;
        end

        qpmm_pe #(
            .PE_LAT (PE_LAT)
        ) i_pe (
            .clk (clk),
            .a   (up.a[j]),
            .b   (b_sel),
            .m   (MPP[j]),
            .q   (q),
            .s   (s_in),
            .sum (pe_sum[j])
        );
    end

    //////////////////////////////////////////////////
    // Alignment with the cells
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= up.valid;
            for (int k = 1; k < PE_LAT; k++) begin
                valid_pipe[k] <= valid_pipe[k-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        a_pipe[0] <= up.a;
        b_pipe[0] <= up.b;
        q_pipe[0] <= q_sum;
        for (int k = 1; k < PE_LAT; k++) begin
            a_pipe[k] <= a_pipe[k-1];
            b_pipe[k] <= b_pipe[k-1];
            q_pipe[k] <= q_pipe[k-1];
        end
    end

    assign down.valid = valid_pipe[PE_LAT-1];
    assign down.a     = a_pipe[PE_LAT-1];
    assign down.b     = b_pipe[PE_LAT-1];

    // Full quotient sum goes down in slot 0, its high part is a carry
    always_comb begin
        down.s[0] = q_pipe[PE_LAT-1];
        for (int j = 0; j < NUM_DIGITS; j++) begin
            down.s[j+1] = pe_sum[j];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/qpmm_stage_if.sv ====
`default_nettype none

interface qpmm_stage_if;
    import qpmm_pkg::*;

    // One item per strobe, every stage takes one each cycle
    logic       valid;

    // Operands travel along with their partial sum
    digit_vec_t a;
    digit_vec_t b;

    // s[0] is the quotient sum of the previous row,
    // s[1..] are the redundant sum digits
    acc_vec_t   s;

    modport src (
        output valid,
        output a,
        output b,
        output s
    );

    modport dst (
        input  valid,
        input  a,
        input  b,
        input  s
    );

endinterface

`default_nettype wire
